/* dv/program_stim.txt */
// Line 1: program word count, commit record count, store record count
// Then program words, commit records (rd data), store records (address data)
0000001C 0000000D 00000002
24010005 24020007 00221821 00612023
3C051234 00A43025 00C33824 0083402A
240AFFFC 0141582A AC060010 8C0C0010
01816821 AC0D0014 10220002 14220002
240E0111 240E0222 08000016 240F0333
AC010000 240F0444 10820001 24100555
8C110014 03E00008 24120001 AC010004
00000001 00000005
00000002 00000007
00000003 0000000C
00000004 00000007
00000005 12340000
00000006 12340007
00000007 00000004
00000008 00000001
0000000A FFFFFFFC
0000000B 00000001
0000000C 12340007
0000000D 1234000C
00000011 1234000C
00000010 12340007
00000014 1234000C

/* build.f */
hdl/mips_pkg.sv
hdl/insn_mem.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/mem_stage.sv
hdl/pipeline.sv
dv/pipeline_asserts.sv
dv/pipeline_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipeline_tb -f build.f

out=$(./obj_dir/Vpipeline_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED"

/* dv/pipeline_tb.sv */
// Testbench for the five-stage pipeline
// Loads the program from the stim file with random valid gaps, then checks
// the commit trace, the store trace and completion against expected records

module pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mips_pkg::*;

    logic      clock;
    logic      rst;
    logic      load_valid;
    word_t     load_word;
    logic      load_last;
    logic      load_ready;
    logic      commit_valid;
    reg_addr_t commit_rd;
    word_t     commit_data;
    logic      store_valid;
    word_t     store_addr;
    word_t     store_data;
    logic      program_done;

    word_t stim [256];
    int    n_prog;
    int    n_commit;
    int    n_store;
    int    commit_base;
    int    store_base;
    int    commit_idx = 0;
    int    store_idx = 0;
    int    value_errors = 0;
    int    event_errors = 0;
    int    flow_errors = 0;
    logic  loaded = 1'b0;
    logic  done_seen = 1'b0;

    pipeline dut_i (
        .clock        (clock),
        .rst          (rst),
        .load_valid   (load_valid),
        .load_word    (load_word),
        .load_last    (load_last),
        .load_ready   (load_ready),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data),
        .store_valid  (store_valid),
        .store_addr   (store_addr),
        .store_data   (store_data),
        .program_done (program_done)
    );

    bind pipeline pipeline_asserts asserts_i (
        .clock        (clock),
        .rst          (rst),
        .load_valid   (load_valid),
        .load_ready   (load_ready),
        .load_last    (load_last),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .store_valid  (store_valid),
        .program_done (program_done)
    );

    always #10 clock = ~clock;

    function automatic word_t stim_word(int pos);
        return stim[pos[7:0]];
    endfunction

    task automatic compare_word(string name, word_t got, word_t expected);
        assert (got === expected) else begin
            $display("[ERROR] %0d ns %s: got %h, expected %h", $time, name, got, expected);
            value_errors++;
        end
    endtask

    task automatic expect_bit(string name, logic got, logic expected);
        assert (got === expected) else begin
            $display("[ERROR] %0d ns %s: got %b, expected %b", $time, name, got, expected);
            flow_errors++;
        end
    endtask

    task automatic watchdog(int cycles);
        repeat (cycles) @(posedge clock);
        $display("Timeout: program not complete after %0d cycles", cycles);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Each word offered with random valid gaps until taken
    task automatic load_program();
        int   idx;
        logic accept;
        idx    = 0;
        accept = 1'b0;
        while (idx < n_prog) begin
            @(negedge clock);
            if (accept) begin
                expect_bit("load_ready", load_ready, idx != n_prog - 1);
                idx++;
            end
            if (idx < n_prog) begin
                load_valid = ($urandom_range(3, 0) != 0);
                load_word  = stim_word(3 + idx);
                load_last  = (idx == n_prog - 1);
            end else begin
                load_valid = 1'b0;
                load_word  = '0;
                load_last  = 1'b0;
            end
            accept = load_valid && load_ready;
        end
    endtask

    // Trace monitor sampled mid-cycle
    always @(negedge clock) begin
        if (!rst) begin
            if (commit_valid) begin
                assert (commit_idx < n_commit) else begin
                    $display("Extra commit to r%0d at %0d ns", commit_rd, $time);
                    event_errors++;
                end
                if (commit_idx < n_commit) begin
                    compare_word("commit_rd", word_t'(commit_rd),
                                 stim_word(commit_base + 2 * commit_idx));
                    compare_word("commit_data", commit_data,
                                 stim_word(commit_base + 2 * commit_idx + 1));
                end
                commit_idx++;
            end
            if (store_valid) begin
                assert (store_idx < n_store) else begin
                    $display("Extra store to %h at %0d ns", store_addr, $time);
                    event_errors++;
                end
                if (store_idx < n_store) begin
                    compare_word("store_addr", store_addr, stim_word(store_base + 2 * store_idx));
                    compare_word("store_data", store_data,
                                 stim_word(store_base + 2 * store_idx + 1));
                end
                store_idx++;
            end
            assert (!loaded || !load_ready) else begin
                $display("load_ready high again at %0d ns after the program load", $time);
                event_errors++;
            end
            assert (!done_seen || program_done) else begin
                $display("program_done fell at %0d ns", $time);
                event_errors++;
            end
            if (program_done) begin
                done_seen = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(32'hfc85f164));
        clock      = 1'b0;
        rst        = 1'b1;
        load_valid = 1'b0;
        load_word  = '0;
        load_last  = 1'b0;
        $readmemh("dv/program_stim.txt", stim);
        n_prog      = stim[0];
        n_commit    = stim[1];
        n_store     = stim[2];
        commit_base = 3 + n_prog;
        store_base  = commit_base + 2 * n_commit;
        fork
            watchdog(100 * n_prog + 200);
        join_none

        repeat (16) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        expect_bit("load_ready", load_ready, 1'b1);
        expect_bit("program_done", program_done, 1'b0);
        expect_bit("commit_valid", commit_valid, 1'b0);
        expect_bit("store_valid", store_valid, 1'b0);

        load_program();
        loaded = 1'b1;

        while (!program_done) begin
            @(negedge clock);
        end
        // Quiet window with no commit or store past the last record
        repeat (20) @(negedge clock);
        expect_bit("program_done", program_done, 1'b1);
        assert (commit_idx == n_commit) else begin
            $display("Saw %0d commits, expected %0d", commit_idx, n_commit);
            flow_errors++;
        end
        assert (store_idx == n_store) else begin
            $display("Saw %0d stores, expected %0d", store_idx, n_store);
            flow_errors++;
        end

        $display("Errors: %0d value, %0d event, %0d flow, %0d assertion",
                 value_errors, event_errors, flow_errors, dut_i.asserts_i.fail_count);
        if (value_errors + event_errors + flow_errors + dut_i.asserts_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* dv/pipeline_asserts.sv */
// Concurrent checks bound to the pipeline top level
// Load handshake, trace ports and completion

module pipeline_asserts (
    input logic                clock,
    input logic                rst,
    input logic                load_valid,
    input logic                load_ready,
    input logic                load_last,
    input logic                commit_valid,
    input mips_pkg::reg_addr_t commit_rd,
    input logic                store_valid,
    input logic                program_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Ready drops right after the last word is taken
    last_word_closes_load: assert property (@(posedge clock) disable iff (rst)
        load_valid && load_ready && load_last |=> !load_ready)
        else begin
            $error("load_ready still high after the last word was accepted");
            fail_count++;
        end

    // Ready holds until the last word is taken
    load_open_until_last: assert property (@(posedge clock) disable iff (rst)
        load_ready && !(load_valid && load_last) |=> load_ready)
        else begin
            $error("load_ready fell before the last word was accepted");
            fail_count++;
        end

    load_stays_closed: assert property (@(posedge clock) disable iff (rst)
        !load_ready |=> !load_ready)
        else begin
            $error("load_ready rose again after the load phase");
            fail_count++;
        end

    quiet_during_load: assert property (@(posedge clock) disable iff (rst)
        load_ready |-> !commit_valid && !store_valid)
        else begin
            $error("Trace activity while the program loads");
            fail_count++;
        end

    done_is_sticky: assert property (@(posedge clock) disable iff (rst)
        program_done |=> program_done)
        else begin
            $error("program_done fell before reset");
            fail_count++;
        end

    // Writes to r0 never show on the trace
    commit_never_r0: assert property (@(posedge clock) disable iff (rst)
        commit_valid |-> commit_rd != '0)
        else begin
            $error("Commit to register 0");
            fail_count++;
        end

endmodule

/* hdl/pipeline.sv */
// Top level of the five-stage pipeline
// Load port, commit and store trace ports, completion flag

module pipeline #(
    parameter int imem_depth = 256,
    parameter int dmem_depth = 256
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                load_valid,
    input  mips_pkg::word_t     load_word,
    input  logic                load_last,
    output logic                load_ready,
    output logic                commit_valid,
    output mips_pkg::reg_addr_t commit_rd,
    output mips_pkg::word_t     commit_data,
    output logic                store_valid,
    output mips_pkg::word_t     store_addr,
    output mips_pkg::word_t     store_data,
    output logic                program_done
);
    import mips_pkg::*;

    word_t     pc, insn, fd_insn, fd_pc, redirect_pc;
    logic      running, fd_valid, stall, redirect, done;
    logic      de_valid, de_reg_we, de_mem_read, de_mem_write, de_use_imm;
    logic      de_branch_eq, de_branch_ne, de_jump, de_jump_reg;
    alu_op_t   de_alu_op;
    reg_addr_t de_rs, de_rt, de_rd, em_rd, wb_rd;
    word_t     de_rs_data, de_rt_data, de_imm, de_pc;
    logic      em_valid, em_reg_we, em_mem_read, em_mem_write, wb_we;
    word_t     em_result, em_store_data, wb_data;

    // Done is the only state that is neither loading nor running
    assign program_done = !load_ready && !running;
    assign commit_valid = wb_we;
    assign commit_rd    = wb_rd;
    assign commit_data  = wb_data;

    insn_mem #(
        .imem_depth (imem_depth)
    ) insn_mem_i (
        .clock      (clock),
        .rst        (rst),
        .load_valid (load_valid),
        .load_word  (load_word),
        .load_last  (load_last),
        .fetch_pc   (pc),
        .done       (done),
        .load_ready (load_ready),
        .insn       (insn),
        .running    (running)
    );

    // Fetch stops in the same cycle jr $31 is seen in execute
    fetch fetch_i (
        .clock       (clock),
        .rst         (rst),
        .running     (running && !done),
        .insn        (insn),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc),
        .fd_valid    (fd_valid),
        .fd_insn     (fd_insn),
        .fd_pc       (fd_pc)
    );

    decode decode_i (
        .clock        (clock),
        .rst          (rst),
        .fd_valid     (fd_valid),
        .fd_insn      (fd_insn),
        .fd_pc        (fd_pc),
        .flush        (redirect || done),
        .ex_load      (de_mem_read),
        .ex_rd        (de_rd),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .stall        (stall),
        .de_valid     (de_valid),
        .de_alu_op    (de_alu_op),
        .de_rs        (de_rs),
        .de_rt        (de_rt),
        .de_rd        (de_rd),
        .de_rs_data   (de_rs_data),
        .de_rt_data   (de_rt_data),
        .de_imm       (de_imm),
        .de_pc        (de_pc),
        .de_reg_we    (de_reg_we),
        .de_mem_read  (de_mem_read),
        .de_mem_write (de_mem_write),
        .de_branch_eq (de_branch_eq),
        .de_branch_ne (de_branch_ne),
        .de_jump      (de_jump),
        .de_jump_reg  (de_jump_reg),
        .de_use_imm   (de_use_imm)
    );

    execute execute_i (
        .clock         (clock),
        .rst           (rst),
        .de_valid      (de_valid),
        .de_alu_op     (de_alu_op),
        .de_rs         (de_rs),
        .de_rt         (de_rt),
        .de_rd         (de_rd),
        .de_rs_data    (de_rs_data),
        .de_rt_data    (de_rt_data),
        .de_imm        (de_imm),
        .de_pc         (de_pc),
        .de_reg_we     (de_reg_we),
        .de_mem_read   (de_mem_read),
        .de_mem_write  (de_mem_write),
        .de_branch_eq  (de_branch_eq),
        .de_branch_ne  (de_branch_ne),
        .de_jump       (de_jump),
        .de_jump_reg   (de_jump_reg),
        .de_use_imm    (de_use_imm),
        .mem_we        (em_reg_we),
        .mem_rd        (em_rd),
        .mem_result    (em_result),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .done          (done),
        .em_valid      (em_valid),
        .em_reg_we     (em_reg_we),
        .em_mem_read   (em_mem_read),
        .em_mem_write  (em_mem_write),
        .em_rd         (em_rd),
        .em_result     (em_result),
        .em_store_data (em_store_data)
    );

    mem_stage #(
        .dmem_depth (dmem_depth)
    ) mem_stage_i (
        .clock         (clock),
        .rst           (rst),
        .em_valid      (em_valid),
        .em_reg_we     (em_reg_we),
        .em_mem_read   (em_mem_read),
        .em_mem_write  (em_mem_write),
        .em_rd         (em_rd),
        .em_result     (em_result),
        .em_store_data (em_store_data),
        .halted        (program_done),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

/* hdl/mem_stage.sv */
// Memory stage
// Data memory, store trace and the memory/write-back register

module mem_stage #(
    parameter int dmem_depth = 256
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                em_valid,
    input  logic                em_reg_we,
    input  logic                em_mem_read,
    input  logic                em_mem_write,
    input  mips_pkg::reg_addr_t em_rd,
    input  mips_pkg::word_t     em_result,
    input  mips_pkg::word_t     em_store_data,
    input  logic                halted,
    output logic                store_valid,
    output mips_pkg::word_t     store_addr,
    output mips_pkg::word_t     store_data,
    output logic                wb_we,
    output mips_pkg::reg_addr_t wb_rd,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    localparam int addr_w = $clog2(dmem_depth);

    word_t             dmem [dmem_depth];
    logic [addr_w-1:0] index;

    // ALU result is the byte address for loads and stores
    assign index       = em_result[2 +: addr_w];
    assign store_valid = em_valid && em_mem_write && !halted;
    assign store_addr  = em_result;
    assign store_data  = em_store_data;

    always_ff @(posedge clock) begin
        if (store_valid) begin
            dmem[index] <= em_store_data;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= em_valid && em_reg_we;
        end
    end

    always_ff @(posedge clock) begin
        wb_rd   <= em_rd;
        wb_data <= em_mem_read ? dmem[index] : em_result;
    end

endmodule

/* hdl/execute.sv */
// Execute stage
// Operand forwarding, ALU, branch and jump resolution,
// completion on jr $31 and the execute/memory register

module execute (
    input  logic                clock,
    input  logic                rst,
    input  logic                de_valid,
    input  mips_pkg::alu_op_t   de_alu_op,
    input  mips_pkg::reg_addr_t de_rs,
    input  mips_pkg::reg_addr_t de_rt,
    input  mips_pkg::reg_addr_t de_rd,
    input  mips_pkg::word_t     de_rs_data,
    input  mips_pkg::word_t     de_rt_data,
    input  mips_pkg::word_t     de_imm,
    input  mips_pkg::word_t     de_pc,
    input  logic                de_reg_we,
    input  logic                de_mem_read,
    input  logic                de_mem_write,
    input  logic                de_branch_eq,
    input  logic                de_branch_ne,
    input  logic                de_jump,
    input  logic                de_jump_reg,
    input  logic                de_use_imm,
    input  logic                mem_we,
    input  mips_pkg::reg_addr_t mem_rd,
    input  mips_pkg::word_t     mem_result,
    input  logic                wb_we,
    input  mips_pkg::reg_addr_t wb_rd,
    input  mips_pkg::word_t     wb_data,
    output logic                redirect,
    output mips_pkg::word_t     redirect_pc,
    output logic                done,
    output logic                em_valid,
    output logic                em_reg_we,
    output logic                em_mem_read,
    output logic                em_mem_write,
    output mips_pkg::reg_addr_t em_rd,
    output mips_pkg::word_t     em_result,
    output mips_pkg::word_t     em_store_data
);
    import mips_pkg::*;

    word_t src_a, src_b, op_b, alu_result, pc_plus4;
    logic  taken, jr_final;

    // Memory stage wins over write-back
    function automatic word_t forward(reg_addr_t r, word_t reg_val);
        if (mem_we && mem_rd == r) begin
            return mem_result;
        end else if (wb_we && wb_rd == r) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    assign src_a    = forward(de_rs, de_rs_data);
    assign src_b    = forward(de_rt, de_rt_data);
    assign op_b     = de_use_imm ? de_imm : src_b;
    assign pc_plus4 = de_pc + word_t'(4);

    always_comb begin
        case (de_alu_op)
            alu_sub: alu_result = src_a - op_b;
            alu_and: alu_result = src_a & op_b;
            alu_or:  alu_result = src_a | op_b;
            alu_slt: alu_result = word_t'($signed(src_a) < $signed(op_b));
            alu_lui: alu_result = {op_b[15:0], 16'b0};
            default: alu_result = src_a + op_b;
        endcase
    end

    assign taken    = (de_branch_eq && src_a == src_b) || (de_branch_ne && src_a != src_b);
    assign jr_final = de_jump_reg && de_rs == reg_addr_t'(31);
    assign redirect = de_valid && (taken || de_jump || (de_jump_reg && !jr_final));
    assign done     = de_valid && jr_final;

    always_comb begin
        if (de_jump_reg) begin
            redirect_pc = src_a;
        end else if (de_jump) begin
            redirect_pc = {pc_plus4[31:28], de_imm[25:0], 2'b00};
        end else begin
            redirect_pc = pc_plus4 + {de_imm[29:0], 2'b00};
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            em_valid     <= 1'b0;
            em_reg_we    <= 1'b0;
            em_mem_read  <= 1'b0;
            em_mem_write <= 1'b0;
        end else begin
            em_valid     <= de_valid;
            em_reg_we    <= de_reg_we;
            em_mem_read  <= de_mem_read;
            em_mem_write <= de_mem_write;
        end
    end

    always_ff @(posedge clock) begin
        em_rd         <= de_rd;
        em_result     <= alu_result;
        em_store_data <= src_b;
    end

endmodule

/* hdl/decode.sv */
// Decode stage
// Instruction decode, register file with write-through,
// load-use hazard detection and the decode/execute register

module decode (
    input  logic                clock,
    input  logic                rst,
    input  logic                fd_valid,
    input  mips_pkg::word_t     fd_insn,
    input  mips_pkg::word_t     fd_pc,
    input  logic                flush,
    input  logic                ex_load,
    input  mips_pkg::reg_addr_t ex_rd,
    input  logic                wb_we,
    input  mips_pkg::reg_addr_t wb_rd,
    input  mips_pkg::word_t     wb_data,
    output logic                stall,
    output logic                de_valid,
    output mips_pkg::alu_op_t   de_alu_op,
    output mips_pkg::reg_addr_t de_rs,
    output mips_pkg::reg_addr_t de_rt,
    output mips_pkg::reg_addr_t de_rd,
    output mips_pkg::word_t     de_rs_data,
    output mips_pkg::word_t     de_rt_data,
    output mips_pkg::word_t     de_imm,
    output mips_pkg::word_t     de_pc,
    output logic                de_reg_we,
    output logic                de_mem_read,
    output logic                de_mem_write,
    output logic                de_branch_eq,
    output logic                de_branch_ne,
    output logic                de_jump,
    output logic                de_jump_reg,
    output logic                de_use_imm
);
    import mips_pkg::*;

    word_t     regs [32];
    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs, rt, rd, dest;
    imm_t      imm16;
    word_t     imm_ext;
    alu_op_t   alu_op;
    logic      reg_we, mem_read, mem_write, use_imm;
    logic      branch_eq, branch_ne, jump, jump_reg;
    logic      rs_used, rt_used;

    // Register 0 reads as zero, a write in the same cycle passes through
    function automatic word_t read_reg(reg_addr_t r);
        if (r == '0) begin
            return '0;
        end else if (wb_we && wb_rd == r) begin
            return wb_data;
        end
        return regs[r];
    endfunction

    assign opcode = fd_insn[31:26];
    assign rs     = fd_insn[25:21];
    assign rt     = fd_insn[20:16];
    assign rd     = fd_insn[15:11];
    assign funct  = fd_insn[5:0];
    assign imm16  = fd_insn[15:0];

    always_comb begin
        alu_op    = alu_add;
        dest      = rt;
        imm_ext   = {{16{imm16[15]}}, imm16};
        reg_we    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_imm   = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        jump      = 1'b0;
        jump_reg  = 1'b0;
        rs_used   = 1'b1;
        rt_used   = 1'b0;
        case (opcode)
            op_rtype: begin
                dest    = rd;
                reg_we  = 1'b1;
                rt_used = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    fn_jr: begin
                        reg_we   = 1'b0;
                        jump_reg = 1'b1;
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            op_addiu: begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            op_lui: begin
                alu_op  = alu_lui;
                imm_ext = {16'b0, imm16};
                use_imm = 1'b1;
                reg_we  = 1'b1;
                rs_used = 1'b0;
            end
            op_lw: begin
                use_imm  = 1'b1;
                reg_we   = 1'b1;
                mem_read = 1'b1;
            end
            op_sw: begin
                use_imm   = 1'b1;
                mem_write = 1'b1;
                rt_used   = 1'b1;
            end
            op_beq: begin
                branch_eq = 1'b1;
                rt_used   = 1'b1;
            end
            op_bne: begin
                branch_ne = 1'b1;
                rt_used   = 1'b1;
            end
            op_j: begin
                // Instruction index rides in the immediate
                imm_ext = {6'b0, fd_insn[25:0]};
                jump    = 1'b1;
                rs_used = 1'b0;
            end
            default: rs_used = 1'b0;
        endcase
    end

    // Load in execute feeding a source here
    assign stall = fd_valid && ex_load && ex_rd != '0 &&
                   ((rs_used && rs == ex_rd) || (rt_used && rt == ex_rd));

    always_ff @(posedge clock) begin
        if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || flush || stall || !fd_valid) begin
            de_valid     <= 1'b0;
            de_alu_op    <= alu_add;
            de_reg_we    <= 1'b0;
            de_mem_read  <= 1'b0;
            de_mem_write <= 1'b0;
            de_branch_eq <= 1'b0;
            de_branch_ne <= 1'b0;
            de_jump      <= 1'b0;
            de_jump_reg  <= 1'b0;
            de_use_imm   <= 1'b0;
        end else begin
            de_valid     <= 1'b1;
            de_alu_op    <= alu_op;
            de_reg_we    <= reg_we && dest != '0;
            de_mem_read  <= mem_read;
            de_mem_write <= mem_write;
            de_branch_eq <= branch_eq;
            de_branch_ne <= branch_ne;
            de_jump      <= jump;
            de_jump_reg  <= jump_reg;
            de_use_imm   <= use_imm;
        end
    end

    always_ff @(posedge clock) begin
        de_rs      <= rs;
        de_rt      <= rt;
        de_rd      <= dest;
        de_rs_data <= read_reg(rs);
        de_rt_data <= read_reg(rt);
        de_imm     <= imm_ext;
        de_pc      <= fd_pc;
    end

endmodule

/* hdl/fetch.sv */
// Fetch stage
// Program counter with redirect and stall hold, fetch/decode register

module fetch (
    input  logic            clock,
    input  logic            rst,
    input  logic            running,
    input  mips_pkg::word_t insn,
    input  logic            stall,
    input  logic            redirect,
    input  mips_pkg::word_t redirect_pc,
    output mips_pkg::word_t pc,
    output logic            fd_valid,
    output mips_pkg::word_t fd_insn,
    output mips_pkg::word_t fd_pc
);
    import mips_pkg::*;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (running && !stall) begin
                pc <= pc + word_t'(4);
            end

            // Squash the fetched word on a taken branch or jump
            if (redirect || !running) begin
                fd_valid <= 1'b0;
            end else if (!stall) begin
                fd_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_insn <= insn;
            fd_pc   <= pc;
        end
    end

endmodule

/* hdl/insn_mem.sv */
// Instruction memory with valid/ready program load port
// Run state machine (load, run, done) and combinational fetch read

module insn_mem #(
    parameter int imem_depth = 256
) (
    input  logic            clock,
    input  logic            rst,
    input  logic            load_valid,
    input  mips_pkg::word_t load_word,
    input  logic            load_last,
    input  mips_pkg::word_t fetch_pc,
    input  logic            done,
    output logic            load_ready,
    output mips_pkg::word_t insn,
    output logic            running
);
    import mips_pkg::*;

    localparam int addr_w = $clog2(imem_depth);

    word_t             mem [imem_depth];
    logic [addr_w-1:0] wr_ptr;
    run_state_t        state;
    logic              accept;

    assign accept     = load_valid && load_ready;
    assign load_ready = (state == st_load);
    assign running    = (state == st_run);
    // Word index wraps at the memory depth
    assign insn       = mem[fetch_pc[2 +: addr_w]];

    always_ff @(posedge clock) begin
        if (accept) begin
            mem[wr_ptr] <= load_word;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state  <= st_load;
            wr_ptr <= '0;
        end else begin
            case (state)
                st_load: begin
                    if (accept) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (load_last) begin
                            state <= st_run;
                        end
                    end
                end
                st_run: begin
                    if (done) begin
                        state <= st_done;
                    end
                end
                default: state <= st_done;
            endcase
        end
    end

endmodule

/* hdl/mips_pkg.sv */
// Shared types and encodings for the MIPS32 subset pipeline
// Word, register, opcode and immediate types, opcode and function codes,
// ALU operation and run state enums

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    // Primary opcodes
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_j     = 6'h02;
    localparam opcode_t op_beq   = 6'h04;
    localparam opcode_t op_bne   = 6'h05;
    localparam opcode_t op_addiu = 6'h09;
    localparam opcode_t op_lui   = 6'h0f;
    localparam opcode_t op_lw    = 6'h23;
    localparam opcode_t op_sw    = 6'h2b;

    // R-type function field
    localparam funct_t fn_jr   = 6'h08;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        st_load,
        st_run,
        st_done
    } run_state_t;

endpackage
